// File: vlog.f
+incdir+tests
rtl/pipeCtrlPkg.sv
rtl/instrDecoder.sv
rtl/stageRegs.sv
rtl/hazardUnit.sv
rtl/forwardUnit.sv
rtl/pipeCtrl.sv
tests/pipeCtrlTb.sv

// File: run.sh
#!/bin/bash
# Build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module pipeCtrlTb -f vlog.f -o pipeCtrlSim \
	&& ./obj_dir/pipeCtrlSim | tee /dev/stderr | grep -q "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tests/ctrlModel.svh
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Predicted decode of the word in decode
////////////////////////////////////////////////////////////////////////////

logic [1:0] pNpc;
logic [1:0] pExt;
logic [3:0] pCmp;
logic [3:0] pAlu;
logic pAluSrc;
logic pMemWrite;
logic [2:0] pWb;
logic [4:0] pDest;
logic [1:0] pUseRs;
logic [1:0] pUseRt;
logic [1:0] pTnew;
logic pStall;

// Modeled stage registers
logic [3:0] qeAluOp;
logic qeAluSrc;
logic [4:0] qeShamt;
logic [4:0] qeRs;
logic [4:0] qeRt;
logic [4:0] qeDest;
logic [1:0] qeTnew;
logic qeMemWrite;
logic [2:0] qeWbSel;
logic qmMemWrite;
logic [4:0] qmRt;
logic [4:0] qmDest;
logic [1:0] qmTnew;
logic [2:0] qmWbSel;
logic [2:0] qwWbSel;
logic [4:0] qwDest;

function automatic logic [3:0] aluForFunct(logic [5:0] fn);
	case (fn)
		fnSub, fnSubu: return aluSub;
		fnAnd: return aluAnd;
		fnOr: return aluOr;
		fnXor: return aluXor;
		fnNor: return aluNor;
		fnSll: return aluSll;
		fnSrl: return aluSrl;
		fnSra: return aluSra;
		fnSllv: return aluSllv;
		fnSrlv: return aluSrlv;
		fnSrav: return aluSrav;
		default: return aluAdd;
	endcase
endfunction

task automatic decodeModel(input logic [31:0] w);
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [4:0] sh;
	logic regAlu;
	op = w[31:26];
	rs = w[25:21];
	rt = w[20:16];
	rd = w[15:11];
	sh = w[10:6];
	fn = w[5:0];
	pNpc = npcSeq;
	pExt = extZero;
	pCmp = cmpEq;
	pAlu = aluAdd;
	pAluSrc = 1'b0;
	pMemWrite = 1'b0;
	pWb = wbAlu;
	pDest = 5'd0;
	pUseRs = 2'd3;
	pUseRt = 2'd3;
	pTnew = 2'd0;
	case (fn)
		fnSll, fnSrl, fnSra: regAlu = rs == 5'd0;
		fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
		fnSllv, fnSrlv, fnSrav, fnSlt, fnSltu: regAlu = sh == 5'd0;
		default: regAlu = 1'b0;
	endcase
	case (op)
		opSpecial: begin
			if (regAlu && (fn == fnSlt || fn == fnSltu)) begin
				pCmp = (fn == fnSlt) ? cmpSlt : cmpSltu;
				pWb = wbCmp;
				pDest = rd;
				pUseRs = 2'd0;
				pUseRt = 2'd0;
			end else if (regAlu) begin
				pAlu = aluForFunct(fn);
				pDest = rd;
				pUseRs = 2'd1;
				pUseRt = 2'd1;
				pTnew = 2'd1;
			end else if (fn == fnJr && rt == 5'd0 && rd == 5'd0 && sh == 5'd0) begin
				pNpc = npcReg;
				pUseRs = 2'd0;
			end else if (fn == fnJalr && rt == 5'd0 && sh == 5'd0) begin
				pNpc = npcReg;
				pWb = wbLink;
				pDest = rd;
				pUseRs = 2'd0;
			end
		end
		opRegimm: begin
			if (rt == 5'd0 || rt == 5'd1) begin
				pNpc = npcBranch;
				pExt = extSign;
				pCmp = (rt == 5'd0) ? cmpLtz : cmpGez;
				pUseRs = 2'd0;
			end
		end
		opBeq, opBne: begin
			pNpc = npcBranch;
			pExt = extSign;
			pCmp = (op == opBeq) ? cmpEq : cmpNe;
			pUseRs = 2'd0;
			pUseRt = 2'd0;
		end
		opBlez, opBgtz: begin
			if (rt == 5'd0) begin
				pNpc = npcBranch;
				pExt = extSign;
				pCmp = (op == opBlez) ? cmpLez : cmpGtz;
				pUseRs = 2'd0;
			end
		end
		opJ: pNpc = npcJump;
		opJal: begin
			pNpc = npcJump;
			pWb = wbLink;
			pDest = 5'd31;
		end
		opAddi, opAddiu, opAndi, opOri, opXori: begin
			pExt = (op == opAddi || op == opAddiu) ? extSign : extZero;
			pAlu = (op == opAndi) ? aluAnd : (op == opOri) ? aluOr :
				(op == opXori) ? aluXor : aluAdd;
			pAluSrc = 1'b1;
			pDest = rt;
			pUseRs = 2'd1;
			pTnew = 2'd1;
		end
		opSlti, opSltiu: begin
			pExt = extSign;
			pCmp = (op == opSlti) ? cmpSlti : cmpSltiu;
			pWb = wbCmp;
			pDest = rt;
			pUseRs = 2'd0;
		end
		opLui: begin
			pExt = extUpper;
			pWb = wbUpper;
			pDest = rt;
		end
		opLw: begin
			pExt = extSign;
			pAluSrc = 1'b1;
			pWb = wbMem;
			pDest = rt;
			pUseRs = 2'd1;
			pTnew = 2'd2;
		end
		opSw: begin
			pExt = extSign;
			pAluSrc = 1'b1;
			pMemWrite = 1'b1;
			pUseRs = 2'd1;
		end
		default: begin
		end
	endcase
endtask

////////////////////////////////////////////////////////////////////////////
// Stall and forwarding rules
////////////////////////////////////////////////////////////////////////////

function automatic logic waitsOn(logic [4:0] src, logic [1:0] tuse);
	if (src == 5'd0)
		return 1'b0;
	return (src == qeDest && tuse < qeTnew) || (src == qmDest && tuse < qmTnew);
endfunction

function automatic logic [1:0] decodeSource(logic [4:0] src);
	if (src == 5'd0)
		return dFwdReg;
	if (src == qeDest && qeTnew == 2'd0)
		return dFwdE;
	if (src == qmDest && qmTnew == 2'd0)
		return dFwdM;
	if (src == qwDest)
		return dFwdW;
	return dFwdReg;
endfunction

function automatic logic [1:0] executeSource(logic [4:0] src);
	if (src == 5'd0)
		return eFwdReg;
	if (src == qmDest && qmTnew == 2'd0)
		return eFwdM;
	if (src == qwDest)
		return eFwdW;
	return eFwdReg;
endfunction

task automatic clearModel();
	qeAluOp = 4'd0;
	qeAluSrc = 1'b0;
	qeShamt = 5'd0;
	qeRs = 5'd0;
	qeRt = 5'd0;
	qeDest = 5'd0;
	qeTnew = 2'd0;
	qeMemWrite = 1'b0;
	qeWbSel = 3'd0;
	qmMemWrite = 1'b0;
	qmRt = 5'd0;
	qmDest = 5'd0;
	qmTnew = 2'd0;
	qmWbSel = 3'd0;
	qwWbSel = 3'd0;
	qwDest = 5'd0;
endtask

// One rising edge; decodeModel must already hold the word's controls
task automatic advanceModel(input logic [31:0] w, input logic held);
	qwWbSel = qmWbSel;
	qwDest = qmDest;
	qmMemWrite = qeMemWrite;
	qmRt = qeRt;
	qmDest = qeDest;
	qmTnew = (qeTnew == 2'd0) ? 2'd0 : qeTnew - 2'd1;
	qmWbSel = qeWbSel;
	if (held) begin
		qeAluOp = 4'd0;
		qeAluSrc = 1'b0;
		qeShamt = 5'd0;
		qeRs = 5'd0;
		qeRt = 5'd0;
		qeDest = 5'd0;
		qeTnew = 2'd0;
		qeMemWrite = 1'b0;
		qeWbSel = 3'd0;
	end else begin
		qeAluOp = pAlu;
		qeAluSrc = pAluSrc;
		qeShamt = w[10:6];
		qeRs = w[25:21];
		qeRt = w[20:16];
		qeDest = pDest;
		qeTnew = pTnew;
		qeMemWrite = pMemWrite;
		qeWbSel = pWb;
	end
endtask

`endif

// File: tests/pipeCtrlTb.sv
`timescale 1ns/10ps

module pipeCtrlTb
	import pipeCtrlPkg::*;
();
	logic clk;
	logic reset;
	logic [31:0] instr;
	logic stall;
	logic [1:0] npcType;
	logic [1:0] extType;
	logic [3:0] cmpType;
	logic [1:0] dFwdRs;
	logic [1:0] dFwdRt;
	logic [3:0] aluOp;
	logic aluSrc;
	logic [4:0] eShamt;
	logic [1:0] eFwdRs;
	logic [1:0] eFwdRt;
	logic memWrite;
	logic mFwdRt;
	logic [2:0] wbSel;
	logic [4:0] wDest;

	logic [15:0] lfsr;
	int errors;
	int checks;
	int testErrors;
	int stalls;
	int cycles;
	int k;
	int rnd;

	`include "ctrlModel.svh"

	pipeCtrl i_pipeCtrl (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.stall(stall),
		.npcType(npcType),
		.extType(extType),
		.cmpType(cmpType),
		.dFwdRs(dFwdRs),
		.dFwdRt(dFwdRt),
		.aluOp(aluOp),
		.aluSrc(aluSrc),
		.eShamt(eShamt),
		.eFwdRs(eFwdRs),
		.eFwdRt(eFwdRt),
		.memWrite(memWrite),
		.mFwdRt(mFwdRt),
		.wbSel(wbSel),
		.wDest(wDest)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic takeBits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic logic [31:0] rWord(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd, logic [4:0] sh);
		return {opSpecial, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] iWord(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// One of the 36 kept instructions by index
	function automatic logic [31:0] buildInstr(int kind, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd, logic [4:0] sh, logic [15:0] imm);
		case (kind)
			0: return rWord(fnAddu, rs, rt, rd, 5'd0);
			1: return rWord(fnSubu, rs, rt, rd, 5'd0);
			2: return rWord(fnAdd, rs, rt, rd, 5'd0);
			3: return rWord(fnSub, rs, rt, rd, 5'd0);
			4: return rWord(fnAnd, rs, rt, rd, 5'd0);
			5: return rWord(fnOr, rs, rt, rd, 5'd0);
			6: return rWord(fnXor, rs, rt, rd, 5'd0);
			7: return rWord(fnNor, rs, rt, rd, 5'd0);
			8: return rWord(fnSllv, rs, rt, rd, 5'd0);
			9: return rWord(fnSrlv, rs, rt, rd, 5'd0);
			10: return rWord(fnSrav, rs, rt, rd, 5'd0);
			11: return rWord(fnSlt, rs, rt, rd, 5'd0);
			12: return rWord(fnSltu, rs, rt, rd, 5'd0);
			13: return rWord(fnSll, 5'd0, rt, rd, sh);
			14: return rWord(fnSrl, 5'd0, rt, rd, sh);
			15: return rWord(fnSra, 5'd0, rt, rd, sh);
			16: return iWord(opAddi, rs, rt, imm);
			17: return iWord(opAddiu, rs, rt, imm);
			18: return iWord(opSlti, rs, rt, imm);
			19: return iWord(opSltiu, rs, rt, imm);
			20: return iWord(opAndi, rs, rt, imm);
			21: return iWord(opOri, rs, rt, imm);
			22: return iWord(opXori, rs, rt, imm);
			23: return iWord(opLui, 5'd0, rt, imm);
			24: return iWord(opLw, rs, rt, imm);
			25: return iWord(opSw, rs, rt, imm);
			26: return iWord(opBeq, rs, rt, imm);
			27: return iWord(opBne, rs, rt, imm);
			28: return iWord(opBlez, rs, 5'd0, imm);
			29: return iWord(opBgtz, rs, 5'd0, imm);
			30: return iWord(opRegimm, rs, rtBltz, imm);
			31: return iWord(opRegimm, rs, rtBgez, imm);
			32: return {opJ, 10'd0, imm};
			33: return {opJal, 10'd0, imm};
			34: return rWord(fnJr, rs, 5'd0, 5'd0, 5'd0);
			default: return rWord(fnJalr, rs, 5'd0, rd, 5'd0);
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////////////////////

	task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic checkOutputs(input logic [31:0] w);
		decodeModel(w);
		pStall = waitsOn(w[25:21], pUseRs) || waitsOn(w[20:16], pUseRt);
		checkVal("stall", 32'(pStall), 32'(stall));
		checkVal("npcType", 32'(pNpc), 32'(npcType));
		checkVal("extType", 32'(pExt), 32'(extType));
		checkVal("cmpType", 32'(pCmp), 32'(cmpType));
		checkVal("dFwdRs", 32'(decodeSource(w[25:21])), 32'(dFwdRs));
		checkVal("dFwdRt", 32'(decodeSource(w[20:16])), 32'(dFwdRt));
		checkVal("aluOp", 32'(qeAluOp), 32'(aluOp));
		checkVal("aluSrc", 32'(qeAluSrc), 32'(aluSrc));
		checkVal("eShamt", 32'(qeShamt), 32'(eShamt));
		checkVal("eFwdRs", 32'(executeSource(qeRs)), 32'(eFwdRs));
		checkVal("eFwdRt", 32'(executeSource(qeRt)), 32'(eFwdRt));
		checkVal("memWrite", 32'(qmMemWrite), 32'(memWrite));
		checkVal("mFwdRt", 32'(qmRt != 5'd0 && qmRt == qwDest), 32'(mFwdRt));
		checkVal("wbSel", 32'(qwWbSel), 32'(wbSel));
		checkVal("wDest", 32'(qwDest), 32'(wDest));
	endtask

	// Called on a falling edge; holds the word while stall is high
	task automatic issue(input logic [31:0] w, output int held);
		logic wasStalled;
		held = 0;
		for (int n = 0; n < 4; n++) begin
			instr = w;
			#2;
			checkOutputs(w);
			wasStalled = pStall;
			advanceModel(w, wasStalled);
			@(negedge clk);
			if (!wasStalled)
				return;
			held++;
		end
		$display("Timeout: instruction %h still stalled after 4 cycles", w);
		$display("Test FAILED");
		$finish;
	endtask

	task automatic nopsUntil(input logic wantStore, input logic [4:0] d, output int n);
		int dummy;
		n = 0;
		while ((wantStore ? !memWrite : wDest != d) && n < 8) begin
			issue(32'd0, dummy);
			n++;
		end
	endtask

	task automatic flush();
		int dummy;
		repeat (3) issue(32'd0, dummy);
	endtask

	task automatic doReset();
		reset = 1'b1;
		instr = 32'd0;
		@(negedge clk);
		@(negedge clk);
		clearModel();
		reset = 1'b0;
	endtask

	task automatic endTest(input int num, input string name);
		$display("test %0d %s: %0d mismatches", num, name, errors - testErrors);
		testErrors = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr = 32'd0;
		lfsr = 16'd73;
		errors = 0;
		checks = 0;
		testErrors = 0;
		clearModel();
		doReset();

		for (int i = 0; i < 36; i++)
			issue(buildInstr(i, 5'd1, 5'd2, 5'd3, 5'd5, 16'h0010), stalls);
		endTest(1, "decode");

		flush();
		issue(iWord(opAddi, 5'd0, 5'd1, 16'h0004), stalls);
		nopsUntil(1'b0, 5'd1, cycles);
		checkVal("wDestDelay", 32'd2, 32'(cycles));
		issue(iWord(opSw, 5'd2, 5'd3, 16'h0008), stalls);
		nopsUntil(1'b1, 5'd0, cycles);
		checkVal("memWriteDelay", 32'd1, 32'(cycles));
		endTest(2, "stage travel");

		flush();
		issue(iWord(opLw, 5'd2, 5'd1, 16'h0000), stalls);
		issue(rWord(fnAddu, 5'd1, 5'd1, 5'd3, 5'd0), stalls);
		checkVal("loadUseStalls", 32'd1, 32'(stalls));
		flush();
		endTest(3, "load-use");

		issue(rWord(fnAddu, 5'd2, 5'd3, 5'd1, 5'd0), stalls);
		issue(rWord(fnAddu, 5'd1, 5'd1, 5'd2, 5'd0), stalls);
		issue(rWord(fnSlt, 5'd2, 5'd1, 5'd3, 5'd0), stalls);
		issue(iWord(opBeq, 5'd3, 5'd1, 16'h0002), stalls);
		issue(iWord(opLui, 5'd0, 5'd1, 16'h1234), stalls);
		issue(iWord(opBeq, 5'd1, 5'd1, 16'h0002), stalls);
		issue(iWord(opLw, 5'd1, 5'd2, 16'h0000), stalls);
		issue(iWord(opSw, 5'd3, 5'd2, 16'h0008), stalls);
		issue(iWord(opSw, 5'd1, 5'd2, 16'h0004), stalls);
		flush();
		endTest(4, "forwarding");

		issue(rWord(fnAddu, 5'd1, 5'd2, 5'd0, 5'd0), stalls);
		issue(iWord(opBeq, 5'd0, 5'd0, 16'h0001), stalls);
		checkVal("zeroRegStalls", 32'd0, 32'(stalls));
		issue(iWord(opLw, 5'd1, 5'd0, 16'h0000), stalls);
		issue(rWord(fnAddu, 5'd0, 5'd0, 5'd1, 5'd0), stalls);
		checkVal("zeroLoadStalls", 32'd0, 32'(stalls));
		issue(iWord(opAddi, 5'd0, 5'd2, 16'h0001), stalls);
		doReset();
		checkVal("resetWDest", 32'd0, 32'(wDest));
		checkVal("resetMemWrite", 32'd0, 32'(memWrite));
		checkVal("resetAluOp", 32'd0, 32'(aluOp));
		issue(32'd0, stalls);
		endTest(5, "register zero and reset");

		for (int i = 0; i < 2000; i++) begin
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] sh;
			logic [15:0] imm;
			takeBits(6, k);
			takeBits(2, rnd);
			rs = 5'(rnd);
			takeBits(2, rnd);
			rt = 5'(rnd);
			takeBits(2, rnd);
			rd = 5'(rnd);
			takeBits(5, rnd);
			sh = 5'(rnd);
			takeBits(4, rnd);
			imm = 16'(rnd);
			issue(buildInstr(k % 36, rs, rt, rd, sh, imm), stalls);
		end
		endTest(6, "random stream");

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: rtl/pipeCtrl.sv
`timescale 1ns/10ps

module pipeCtrl
	import pipeCtrlPkg::*;
(
	input logic clk,
	input logic reset,
	input instrWord_t instr,
	output logic stall,
	output npcType_t npcType,
	output extType_t extType,
	output cmpType_t cmpType,
	output dFwdSel_t dFwdRs,
	output dFwdSel_t dFwdRt,
	output aluOp_t aluOp,
	output logic aluSrc,
	output logic [4:0] eShamt,
	output eFwdSel_t eFwdRs,
	output eFwdSel_t eFwdRt,
	output logic memWrite,
	output logic mFwdRt,
	output wbSel_t wbSel,
	output regAddr_t wDest
);
	// Decode-stage controls
	aluOp_t dAluOp;
	logic dAluSrc;
	logic dMemWrite;
	wbSel_t dWbSel;
	regAddr_t dDest;
	stageTime_t tuseRs;
	stageTime_t tuseRt;
	stageTime_t tnew;

	// In-flight register numbers and new times
	regAddr_t eRs;
	regAddr_t eRt;
	regAddr_t eDest;
	stageTime_t eTnew;
	regAddr_t mRt;
	regAddr_t mDest;
	stageTime_t mTnew;

	instrDecoder i_instrDecoder (
		.instr(instr),
		.npcType(npcType),
		.extType(extType),
		.cmpType(cmpType),
		.aluOp(dAluOp),
		.aluSrc(dAluSrc),
		.memWrite(dMemWrite),
		.wbSel(dWbSel),
		.dest(dDest),
		.tuseRs(tuseRs),
		.tuseRt(tuseRt),
		.tnew(tnew)
	);

	stageRegs i_stageRegs (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.instr(instr),
		.aluOp(dAluOp),
		.aluSrc(dAluSrc),
		.memWrite(dMemWrite),
		.wbSel(dWbSel),
		.dest(dDest),
		.tnew(tnew),
		.eAluOp(aluOp),
		.eAluSrc(aluSrc),
		.eShamt(eShamt),
		.eRs(eRs),
		.eRt(eRt),
		.eDest(eDest),
		.eTnew(eTnew),
		.mMemWrite(memWrite),
		.mRt(mRt),
		.mDest(mDest),
		.mTnew(mTnew),
		.wWbSel(wbSel),
		.wDest(wDest)
	);

	hazardUnit i_hazardUnit (
		.clk(clk),
		.instr(instr),
		.tuseRs(tuseRs),
		.tuseRt(tuseRt),
		.eDest(eDest),
		.eTnew(eTnew),
		.mDest(mDest),
		.mTnew(mTnew),
		.stall(stall)
	);

	forwardUnit i_forwardUnit (
		.clk(clk),
		.instr(instr),
		.eRs(eRs),
		.eRt(eRt),
		.mRt(mRt),
		.eDest(eDest),
		.eTnew(eTnew),
		.mDest(mDest),
		.mTnew(mTnew),
		.wDest(wDest),
		.dFwdRs(dFwdRs),
		.dFwdRt(dFwdRt),
		.eFwdRs(eFwdRs),
		.eFwdRt(eFwdRt),
		.mFwdRt(mFwdRt)
	);

endmodule

// File: rtl/forwardUnit.sv
`timescale 1ns/10ps

module forwardUnit
	import pipeCtrlPkg::*;
(
	input logic clk,
	input instrWord_t instr,
	input regAddr_t eRs,
	input regAddr_t eRt,
	input regAddr_t mRt,
	input regAddr_t eDest,
	input stageTime_t eTnew,
	input regAddr_t mDest,
	input stageTime_t mTnew,
	input regAddr_t wDest,
	output dFwdSel_t dFwdRs,
	output dFwdSel_t dFwdRt,
	output eFwdSel_t eFwdRs,
	output eFwdSel_t eFwdRt,
	output logic mFwdRt
);

	// Youngest ready producer wins
	function automatic dFwdSel_t pickD(regAddr_t src);
		if (src == '0)
			return dFwdReg;
		if (src == eDest && eTnew == 2'd0)
			return dFwdE;
		if (src == mDest && mTnew == 2'd0)
			return dFwdM;
		if (src == wDest)
			return dFwdW;
		return dFwdReg;
	endfunction

	function automatic eFwdSel_t pickE(regAddr_t src);
		if (src == '0)
			return eFwdReg;
		if (src == mDest && mTnew == 2'd0)
			return eFwdM;
		if (src == wDest)
			return eFwdW;
		return eFwdReg;
	endfunction

	always_comb begin
		dFwdRs = pickD(instr.r.rs);
		dFwdRt = pickD(instr.r.rt);
		eFwdRs = pickE(eRs);
		eFwdRt = pickE(eRt);
		// Store data only
		mFwdRt = mRt != '0 && mRt == wDest;
	end

	zeroNeverForwards: assert property (@(posedge clk)
		(instr.r.rs != '0 || dFwdRs == dFwdReg) && (instr.r.rt != '0 || dFwdRt == dFwdReg) &&
		(eRs != '0 || eFwdRs == eFwdReg) && (eRt != '0 || eFwdRt == eFwdReg) &&
		(mRt != '0 || !mFwdRt));

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit
	import pipeCtrlPkg::*;
(
	input logic clk,
	input instrWord_t instr,
	input stageTime_t tuseRs,
	input stageTime_t tuseRt,
	input regAddr_t eDest,
	input stageTime_t eTnew,
	input regAddr_t mDest,
	input stageTime_t mTnew,
	output logic stall
);
	logic rsStall;
	logic rtStall;

	// Operand needed before an in-flight producer has its result
	function automatic logic mustWait(regAddr_t src, stageTime_t tuse, regAddr_t eDst,
			stageTime_t eT, regAddr_t mDst, stageTime_t mT);
		logic eHit;
		logic mHit;
		eHit = src == eDst && tuse < eT;
		mHit = src == mDst && tuse < mT;
		return src != '0 && (eHit || mHit);
	endfunction

	always_comb begin
		rsStall = mustWait(instr.r.rs, tuseRs, eDest, eTnew, mDest, mTnew);
		rtStall = mustWait(instr.r.rt, tuseRt, eDest, eTnew, mDest, mTnew);
	end

	assign stall = rsStall || rtStall;

	// Register zero never waits on a producer
	noStallOnZeroRegs: assert property (@(posedge clk)
		(instr.r.rs == '0 && instr.r.rt == '0) |-> !stall);

endmodule

// File: rtl/stageRegs.sv
`timescale 1ns/10ps

module stageRegs
	import pipeCtrlPkg::*;
(
	input logic clk,
	input logic reset,
	input logic stall,
	input instrWord_t instr,
	input aluOp_t aluOp,
	input logic aluSrc,
	input logic memWrite,
	input wbSel_t wbSel,
	input regAddr_t dest,
	input stageTime_t tnew,
	output aluOp_t eAluOp,
	output logic eAluSrc,
	output logic [4:0] eShamt,
	output regAddr_t eRs,
	output regAddr_t eRt,
	output regAddr_t eDest,
	output stageTime_t eTnew,
	output logic mMemWrite,
	output regAddr_t mRt,
	output regAddr_t mDest,
	output stageTime_t mTnew,
	output wbSel_t wWbSel,
	output regAddr_t wDest
);
	logic eMemWrite;
	wbSel_t eWbSel;
	wbSel_t mWbSel;

	////////////////////////////////////////////////////////////////////////////
	// Execute stage with a bubble while decode is held
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || stall) begin
			eAluOp <= aluAdd;
			eAluSrc <= 1'b0;
			eShamt <= '0;
			eRs <= '0;
			eRt <= '0;
			eDest <= '0;
			eTnew <= 2'd0;
			eMemWrite <= 1'b0;
			eWbSel <= wbAlu;
		end else begin
			eAluOp <= aluOp;
			eAluSrc <= aluSrc;
			eShamt <= instr.r.shamt;
			eRs <= instr.r.rs;
			eRt <= instr.r.rt;
			eDest <= dest;
			eTnew <= tnew;
			eMemWrite <= memWrite;
			eWbSel <= wbSel;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory and write-back stages
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			mMemWrite <= 1'b0;
			mRt <= '0;
			mDest <= '0;
			mTnew <= 2'd0;
			mWbSel <= wbAlu;
			wWbSel <= wbAlu;
			wDest <= '0;
		end else begin
			mMemWrite <= eMemWrite;
			mRt <= eRt;
			mDest <= eDest;
			// One cycle closer to the result and floored at zero
			mTnew <= (eTnew == 2'd0) ? 2'd0 : eTnew - 2'd1;
			mWbSel <= eWbSel;
			wWbSel <= mWbSel;
			wDest <= mDest;
		end
	end

	// A held instruction must not leave a copy of itself in execute
	bubbleOnStall: assert property (@(posedge clk) disable iff (reset)
		stall |=> eDest == '0 && eTnew == 2'd0);

endmodule

// File: rtl/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder
	import pipeCtrlPkg::*;
(
	input instrWord_t instr,
	output npcType_t npcType,
	output extType_t extType,
	output cmpType_t cmpType,
	output aluOp_t aluOp,
	output logic aluSrc,
	output logic memWrite,
	output wbSel_t wbSel,
	output regAddr_t dest,
	output stageTime_t tuseRs,
	output stageTime_t tuseRt,
	output stageTime_t tnew
);
	logic shamtZero;
	logic rsZero;
	logic rtZero;
	logic rAluFmt;
	logic rCmp;
	logic jrHit;
	logic jalrHit;
	aluOp_t rAluOp;

	assign shamtZero = instr.r.shamt == '0;
	assign rsZero = instr.r.rs == '0;
	assign rtZero = instr.r.rt == '0;
	assign rCmp = instr.r.funct == fnSlt || instr.r.funct == fnSltu;
	assign jrHit = instr.r.funct == fnJr && rtZero && instr.r.rd == '0 && shamtZero;
	assign jalrHit = instr.r.funct == fnJalr && rtZero && shamtZero;

	// Register-format ALU words and their zero fields
	always_comb begin
		case (instr.r.funct)
			fnSll, fnSrl, fnSra: rAluFmt = rsZero;
			fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
			fnSllv, fnSrlv, fnSrav, fnSlt, fnSltu: rAluFmt = shamtZero;
			default: rAluFmt = 1'b0;
		endcase
	end

	always_comb begin
		case (instr.r.funct)
			fnSub, fnSubu: rAluOp = aluSub;
			fnAnd: rAluOp = aluAnd;
			fnOr: rAluOp = aluOr;
			fnXor: rAluOp = aluXor;
			fnNor: rAluOp = aluNor;
			fnSll: rAluOp = aluSll;
			fnSrl: rAluOp = aluSrl;
			fnSra: rAluOp = aluSra;
			fnSllv: rAluOp = aluSllv;
			fnSrlv: rAluOp = aluSrlv;
			fnSrav: rAluOp = aluSrav;
			default: rAluOp = aluAdd;
		endcase
	end

	always_comb begin
		// Defaults describe a no-op
		npcType = npcSeq;
		extType = extZero;
		cmpType = cmpEq;
		aluOp = aluAdd;
		aluSrc = 1'b0;
		memWrite = 1'b0;
		wbSel = wbAlu;
		dest = '0;
		tuseRs = tNever;
		tuseRt = tNever;
		tnew = 2'd0;
		case (instr.i.op)
			opSpecial: begin
				if (rAluFmt) begin
					aluOp = rAluOp;
					dest = instr.r.rd;
					tuseRs = 2'd1;
					tuseRt = 2'd1;
					tnew = 2'd1;
					if (rCmp) begin
						cmpType = (instr.r.funct == fnSlt) ? cmpSlt : cmpSltu;
						wbSel = wbCmp;
						tuseRs = 2'd0;
						tuseRt = 2'd0;
						tnew = 2'd0;
					end
				end else if (jrHit || jalrHit) begin
					npcType = npcReg;
					tuseRs = 2'd0;
					if (jalrHit) begin
						wbSel = wbLink;
						dest = instr.r.rd;
					end
				end
			end
			opRegimm: begin
				if (instr.i.rt == rtBltz || instr.i.rt == rtBgez) begin
					npcType = npcBranch;
					extType = extSign;
					cmpType = (instr.i.rt == rtBltz) ? cmpLtz : cmpGez;
					tuseRs = 2'd0;
				end
			end
			opBeq, opBne: begin
				npcType = npcBranch;
				extType = extSign;
				cmpType = (instr.i.op == opBeq) ? cmpEq : cmpNe;
				tuseRs = 2'd0;
				tuseRt = 2'd0;
			end
			opBlez, opBgtz: begin
				if (instr.i.rt == '0) begin
					npcType = npcBranch;
					extType = extSign;
					cmpType = (instr.i.op == opBlez) ? cmpLez : cmpGtz;
					tuseRs = 2'd0;
				end
			end
			opJ: npcType = npcJump;
			opJal: begin
				npcType = npcJump;
				wbSel = wbLink;
				dest = linkReg;
			end
			opAddi, opAddiu, opAndi, opOri, opXori: begin
				extType = (instr.i.op == opAddi || instr.i.op == opAddiu) ? extSign : extZero;
				aluSrc = 1'b1;
				dest = instr.i.rt;
				tuseRs = 2'd1;
				tnew = 2'd1;
				case (instr.i.op)
					opAndi: aluOp = aluAnd;
					opOri: aluOp = aluOr;
					opXori: aluOp = aluXor;
					default: aluOp = aluAdd;
				endcase
			end
			opSlti, opSltiu: begin
				extType = extSign;
				cmpType = (instr.i.op == opSlti) ? cmpSlti : cmpSltiu;
				wbSel = wbCmp;
				dest = instr.i.rt;
				tuseRs = 2'd0;
			end
			opLui: begin
				extType = extUpper;
				wbSel = wbUpper;
				dest = instr.i.rt;
			end
			opLw, opSw: begin
				extType = extSign;
				aluSrc = 1'b1;
				tuseRs = 2'd1;
				if (instr.i.op == opLw) begin
					wbSel = wbMem;
					dest = instr.i.rt;
					tnew = 2'd2;
				end else begin
					memWrite = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// File: rtl/pipeCtrlPkg.sv
package pipeCtrlPkg;

	typedef logic [4:0] regAddr_t;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opRegimm  = 6'b000001;
	localparam logic [5:0] opJ       = 6'b000010;
	localparam logic [5:0] opJal     = 6'b000011;
	localparam logic [5:0] opBeq     = 6'b000100;
	localparam logic [5:0] opBne     = 6'b000101;
	localparam logic [5:0] opBlez    = 6'b000110;
	localparam logic [5:0] opBgtz    = 6'b000111;
	localparam logic [5:0] opAddi    = 6'b001000;
	localparam logic [5:0] opAddiu   = 6'b001001;
	localparam logic [5:0] opSlti    = 6'b001010;
	localparam logic [5:0] opSltiu   = 6'b001011;
	localparam logic [5:0] opAndi    = 6'b001100;
	localparam logic [5:0] opOri     = 6'b001101;
	localparam logic [5:0] opXori    = 6'b001110;
	localparam logic [5:0] opLui     = 6'b001111;
	localparam logic [5:0] opLw      = 6'b100011;
	localparam logic [5:0] opSw      = 6'b101011;

	// Function field of SPECIAL words
	localparam logic [5:0] fnSll  = 6'b000000;
	localparam logic [5:0] fnSrl  = 6'b000010;
	localparam logic [5:0] fnSra  = 6'b000011;
	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSrlv = 6'b000110;
	localparam logic [5:0] fnSrav = 6'b000111;
	localparam logic [5:0] fnJr   = 6'b001000;
	localparam logic [5:0] fnJalr = 6'b001001;
	localparam logic [5:0] fnAdd  = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub  = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnXor  = 6'b100110;
	localparam logic [5:0] fnNor  = 6'b100111;
	localparam logic [5:0] fnSlt  = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

	// REGIMM selects the branch in rt
	localparam regAddr_t rtBltz = 5'b00000;
	localparam regAddr_t rtBgez = 5'b00001;

	localparam regAddr_t linkReg = 5'd31;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] op;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0] op;
		regAddr_t rs;
		regAddr_t rt;
		logic [15:0] imm;
	} iFields_t;

	typedef union packed {
		rFields_t r;
		iFields_t i;
	} instrWord_t;

	typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcReg} npcType_t;
	typedef enum logic [1:0] {extZero, extSign, extUpper} extType_t;
	typedef enum logic [3:0] {
		cmpEq, cmpNe, cmpLez, cmpGtz, cmpLtz, cmpGez, cmpSlt, cmpSlti, cmpSltiu, cmpSltu
	} cmpType_t;
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSll, aluSrl, aluSra, aluSllv, aluSrlv, aluSrav,
		aluXor, aluNor
	} aluOp_t;
	typedef enum logic [2:0] {wbAlu, wbMem, wbLink, wbUpper, wbCmp} wbSel_t;

	// Cycles until an operand is needed or a result exists
	typedef logic [1:0] stageTime_t;
	localparam stageTime_t tNever = 2'd3;

	typedef enum logic [1:0] {dFwdReg, dFwdW, dFwdM, dFwdE} dFwdSel_t;
	typedef enum logic [1:0] {eFwdReg, eFwdW, eFwdM} eFwdSel_t;

endpackage
